// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FILELIST  ?= exec_stage.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
LINT_OPTS ?= --lint-only -Wall --timing --assert
SIM_OPTS  ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_OPTS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: dv/exec_stage_assertions.sv
`default_nettype none

module exec_stage_assertions
    import exec_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input logic            in_valid,
    input trap_e           in_trap,
    input exe_op_e         in_ctrl,
    input exe_src_e        in_src,
    input logic [XLEN-1:0] rs1_data,
    input logic [XLEN-1:0] rs2_data,
    input logic [XLEN-1:0] csr_data,
    input logic [XLEN-1:0] imm,
    input logic [XLEN-1:0] zimm,
    input logic [XLEN-1:0] pc,
    input logic [4:0]      in_rd,
    input logic            out_valid,
    input logic [4:0]      out_rd,
    input logic [XLEN-1:0] out_data
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [XLEN-1:0] MIN64 = 64'h8000_0000_0000_0000;

    int              fail_count = 0;
    logic [2:0]      run_hist   = '0;  // rst_n at the last three edges
    logic [2:0]      rst_hist   = '0;  // Reset seen at the last three edges
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic            squash;
    logic [XLEN-1:0] expect_now;

    // Reference result of one operation on already selected operands
    function automatic logic [XLEN-1:0] model(input exe_op_e ctrl, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] wide_a;
        logic signed [2*XLEN-1:0] wide_b;
        logic [XLEN-1:0]          q;
        logic [XLEN-1:0]          m;
        logic [31:0]              aw;
        logic [31:0]              bw;
        logic [31:0]              qw;
        logic [31:0]              mw;
        logic [31:0]              w;
        logic [XLEN-1:0]          r;
        aw = a[31:0];
        bw = b[31:0];
        wide_a = $signed(a);
        wide_b = $signed(b);
        if (ctrl == MULHSU)
            wide_b[2*XLEN-1:XLEN] = '0;  // Second operand counts as unsigned
        q = '1;  // Division by zero unless replaced below
        m = a;
        if (b != '0) begin
            if (a == MIN64 && b == '1) begin
                q = a;
                m = '0;
            end else begin
                q = $signed(a) / $signed(b);
                m = $signed(a) % $signed(b);
            end
        end
        qw = '1;
        mw = aw;
        if (bw != '0) begin
            if (aw == 32'h8000_0000 && bw == '1) begin
                qw = aw;
                mw = '0;
            end else begin
                qw = $signed(aw) / $signed(bw);
                mw = $signed(aw) % $signed(bw);
            end
        end
        r = '0;
        w = '0;
        case (ctrl)
            SLL:          r = a << b[5:0];
            SRL:          r = a >> b[5:0];
            SRA:          r = $signed(a) >>> b[5:0];
            ADD:          r = a + b;
            SUB:          r = a - b;
            XOR:          r = a ^ b;
            OR:           r = a | b;
            AND:          r = a & b;
            SLT:          r = XLEN'($signed(a) < $signed(b));
            SLTU:         r = XLEN'(a < b);
            MUL:          r = a * b;
            MULH, MULHSU: r = XLEN'((wide_a * wide_b) >> XLEN);
            DIV:          r = q;
            DIVU:         r = (b == '0) ? '1 : a / b;
            REM:          r = m;
            REMU:         r = (b == '0) ? a : a % b;
            SLLW:         w = aw << b[4:0];
            SRLW:         w = aw >> b[4:0];
            SRAW:         w = $signed(aw) >>> b[4:0];
            ADDW:         w = aw + bw;
            SUBW:         w = aw - bw;
            MULW:         w = aw * bw;
            DIVW:         w = qw;
            DIVUW:        w = (bw == '0) ? '1 : aw / bw;
            REMW:         w = mw;
            REMUW:        w = (bw == '0) ? aw : aw % bw;
            default:      r = '0;
        endcase
        return (ctrl >= SLLW) ? {{32{w[31]}}, w} : r;
    endfunction

    always_comb begin
        case (in_src)
            R_R:         {opa, opb} = {rs1_data, rs2_data};
            R_I:         {opa, opb} = {rs1_data, imm};
            PC_I:        {opa, opb} = {pc, imm};
            R_CSR:       {opa, opb} = {rs1_data, csr_data};
            NOTR_CSR:    {opa, opb} = {~rs1_data, csr_data};
            CSR_ZIMM:    {opa, opb} = {csr_data, zimm};
            CSR_NOTZIMM: {opa, opb} = {csr_data, ~zimm};
            default:     {opa, opb} = '0;
        endcase
        squash     = !in_valid || (in_trap != TRAP_NONE) || (in_ctrl == NOP);
        expect_now = squash ? '0 : model(in_ctrl, opa, opb);
    end

    always_ff @(posedge clk) begin
        run_hist <= {run_hist[1:0], rst_n};
        rst_hist <= {rst_hist[1:0], !rst_n};
    end

    // ====================
    // Output checks
    // ====================

    // Every stage is cleared, so nothing reaches the outputs for three cycles
    assert property (@(posedge clk) |rst_hist |-> !out_valid && out_data == '0)
        else begin
            fail_count++;
            $error("Outputs not cleared in the three cycles after reset");
        end

    assert property (@(posedge clk) &run_hist |-> out_valid == $past(in_valid, 3))
        else begin
            fail_count++;
            $error("out_valid does not follow in_valid three cycles later");
        end

    assert property (@(posedge clk) &run_hist && $past(in_valid, 3) |-> out_rd == $past(in_rd, 3))
        else begin
            fail_count++;
            $error("out_rd lost or reordered");
        end

    assert property (@(posedge clk) &run_hist |-> out_data == $past(expect_now, 3))
        else begin
            fail_count++;
            $error("out_data differs from the reference model");
        end

endmodule

`default_nettype wire

// File: dv/exec_stage_tb.sv
`default_nettype none

module exec_stage_tb
    import exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 4;
    localparam int SEED        = 90558;
    localparam int TEST_CYCLES = 366;  // Reset, six tests and their drains
    localparam logic [XLEN-1:0] MIN64 = 64'h8000_0000_0000_0000;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    trap_e           in_trap;
    exe_op_e         in_ctrl;
    exe_src_e        in_src;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] csr_data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] zimm;
    logic [XLEN-1:0] pc;
    logic [4:0]      in_rd;
    logic            out_valid;
    logic [4:0]      out_rd;
    logic [XLEN-1:0] out_data;
    int              seen_fails = 0;
    int              passed     = 0;
    int              failed     = 0;

    exec_stage_top dut0 (.*);

    bind exec_stage_top exec_stage_assertions exec_chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + 50) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [XLEN-1:0] rand_word();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [XLEN-1:0] with_upper(input logic [31:0] lo);
        return {$urandom(), lo};  // Random upper half that W operations must ignore
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic idle();
        in_valid = 1'b0;
        tick();
    endtask

    task automatic issue(input exe_op_e ctrl, input exe_src_e src, input trap_e trap,
                         input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        in_valid = 1'b1;
        in_ctrl  = ctrl;
        in_src   = src;
        in_trap  = trap;
        in_rd    = 5'($urandom);
        rs1_data = a;
        rs2_data = b;
        csr_data = rand_word();
        imm      = rand_word();
        zimm     = {59'b0, 5'($urandom)};
        pc       = rand_word();
        tick();
    endtask

    task automatic finish_test(input string name);
        int failures;
        idle();
        repeat (2) tick();  // The last operation leaves the pipeline here
        failures   = dut0.exec_chk0.fail_count - seen_fails;
        seen_fails = dut0.exec_chk0.fail_count;
        if (failures == 0) begin
            $display("PASSED %s", name);
            passed++;
        end else begin
            $display("FAILED %s: expected 0 assertion failures, actual %0d", name, failures);
            failed++;
        end
    endtask

    // ====================
    // Tests
    // ====================

    task automatic reset_latency();
        for (int i = 0; i < 8; i++) begin
            if (i % 3 == 1)
                idle();
            else
                issue(ADD, R_I, TRAP_NONE, rand_word(), rand_word());
        end
        // Two valid operations are in flight when reset hits
        issue(ADD, R_I, TRAP_NONE, rand_word(), rand_word());
        issue(ADD, R_I, TRAP_NONE, rand_word(), rand_word());
        rst_n = 1'b0;
        issue(ADD, R_I, TRAP_NONE, rand_word(), rand_word());
        rst_n = 1'b1;
        finish_test("reset_latency");
    endtask

    task automatic alu_ops();
        exe_op_e ops[10];
        ops = '{ADD, SUB, XOR, OR, AND, SLT, SLTU, SLL, SRL, SRA};
        for (int s = 0; s < 8; s++) begin
            foreach (ops[k])
                issue(ops[k], exe_src_e'(s), TRAP_NONE, rand_word(), rand_word());
        end
        finish_test("alu_ops");
    endtask

    task automatic multiply();
        exe_op_e         mul_ops[4];
        logic [XLEN-1:0] corner[4];
        mul_ops = '{MUL, MULH, MULHSU, MULW};
        corner  = '{'0, '1, MIN64, 64'd7};
        foreach (mul_ops[k]) begin
            foreach (corner[i]) begin
                foreach (corner[j])
                    issue(mul_ops[k], R_R, TRAP_NONE, corner[i], corner[j]);
            end
            repeat (8) issue(mul_ops[k], R_R, TRAP_NONE, rand_word(), rand_word());
        end
        finish_test("multiply");
    endtask

    task automatic divide();
        exe_op_e div_ops[8];
        div_ops = '{DIV, DIVU, REM, REMU, DIVW, DIVUW, REMW, REMUW};
        foreach (div_ops[k]) begin
            issue(div_ops[k], R_R, TRAP_NONE, rand_word(), '0);
            issue(div_ops[k], R_R, TRAP_NONE, MIN64, '1);
            issue(div_ops[k], R_R, TRAP_NONE, with_upper(32'h8000_0000),
                  with_upper(32'hffff_ffff));
            issue(div_ops[k], R_R, TRAP_NONE, rand_word(), with_upper(32'h0));
            repeat (2) issue(div_ops[k], R_R, TRAP_NONE, rand_word(), rand_word());
        end
        finish_test("divide");
    endtask

    task automatic word_ops();
        exe_op_e w_ops[5];
        w_ops = '{SLLW, SRLW, SRAW, ADDW, SUBW};
        foreach (w_ops[k])
            repeat (10) issue(w_ops[k], R_R, TRAP_NONE, with_upper($urandom), rand_word());
        finish_test("word_ops");
    endtask

    task automatic zero_mix();
        trap_e   trap;
        exe_op_e ctrl;
        for (int i = 0; i < 60; i++) begin
            trap = ($urandom % 3 == 0) ? trap_e'(1 + $urandom % 15) : TRAP_NONE;
            ctrl = (i % 10 == 0) ? NOP : exe_op_e'($urandom % 28);
            issue(ctrl, exe_src_e'($urandom % 8), trap, rand_word(), rand_word());
        end
        finish_test("zero_mix");
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_trap  = TRAP_NONE;
        in_ctrl  = NOP;
        in_src   = SRC_NOP;
        in_rd    = '0;
        rs1_data = '0;
        rs2_data = '0;
        csr_data = '0;
        imm      = '0;
        zimm     = '0;
        pc       = '0;
        repeat (3) tick();
        rst_n = 1'b1;
        reset_latency();
        alu_ops();
        multiply();
        divide();
        word_ops();
        zero_mix();
        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_stage.f
hw/exec_pkg.sv
hw/exec_op_if.sv
hw/exec_operand_select.sv
hw/exec_alu.sv
hw/exec_result_format.sv
hw/exec_stage_top.sv
dv/exec_stage_assertions.sv
dv/exec_stage_tb.sv

// File: hw/exec_alu.sv
`default_nettype none

module exec_alu
    import exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    exec_op_if.recv op,
    exec_op_if.send res
);

    localparam logic [XLEN-1:0] MIN_S64 = {1'b1, {(XLEN-1){1'b0}}};

    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [2*XLEN-1:0] mul_a;
    logic [2*XLEN-1:0] mul_b;
    logic [2*XLEN-1:0] product;
    logic [XLEN-1:0]   div_a;
    logic [XLEN-1:0]   div_b;
    logic              div_by_zero;
    logic              div_ovf;
    logic [XLEN-1:0]   quot_s;
    logic [XLEN-1:0]   rem_s;
    logic [XLEN-1:0]   quot_u;
    logic [XLEN-1:0]   rem_u;
    exe_word_u         res_word;
    logic              is_word;

    assign a = op.src1.full;
    assign b = op.src2;

    // ====================
    // Multiplier
    // ====================

    // A single 128-bit product serves MUL, MULH, MULHSU and MULW
    assign mul_a = {{XLEN{a[XLEN-1]}}, a};
    assign mul_b = (op.ctrl == MULHSU) ? {{XLEN{1'b0}}, b} : {{XLEN{b[XLEN-1]}}, b};
    assign product = mul_a * mul_b;

    // ====================
    // Divider
    // ====================

    // W forms are extended to 64 bits, so the same zero and overflow rules
    // give the right lower half
    always_comb begin
        case (op.ctrl)
            DIVW, REMW: begin
                div_a = {{32{a[31]}}, a[31:0]};
                div_b = {{32{b[31]}}, b[31:0]};
            end
            DIVUW, REMUW: begin
                div_a = {32'b0, a[31:0]};
                div_b = {32'b0, b[31:0]};
            end
            default: begin
                div_a = a;
                div_b = b;
            end
        endcase
    end

    assign div_by_zero = (div_b == '0);
    assign div_ovf     = (div_a == MIN_S64) && (div_b == '1);

    always_comb begin
        if (div_by_zero) begin
            quot_s = '1;
            rem_s  = div_a;
        end else if (div_ovf) begin
            quot_s = div_a;     // Most negative divided by minus one
            rem_s  = '0;
        end else begin
            quot_s = $signed(div_a) / $signed(div_b);
            rem_s  = $signed(div_a) % $signed(div_b);
        end
    end

    assign quot_u = div_by_zero ? '1 : div_a / div_b;
    assign rem_u  = div_by_zero ? div_a : div_a % div_b;

    // ====================
    // Result select
    // ====================

    always_comb begin
        res_word = '0;
        case (op.ctrl)
            SLL:          res_word.full = a << b[5:0];
            SRL:          res_word.full = a >> b[5:0];
            SRA:          res_word.full = $signed(a) >>> b[5:0];
            ADD:          res_word.full = a + b;
            SUB:          res_word.full = a - b;
            XOR:          res_word.full = a ^ b;
            OR:           res_word.full = a | b;
            AND:          res_word.full = a & b;
            SLT:          res_word.full = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:         res_word.full = {{(XLEN-1){1'b0}}, a < b};
            MUL:          res_word.full = product[XLEN-1:0];
            MULH, MULHSU: res_word.full = product[2*XLEN-1:XLEN];
            DIV:          res_word.full = quot_s;
            DIVU:         res_word.full = quot_u;
            REM:          res_word.full = rem_s;
            REMU:         res_word.full = rem_u;
            SLLW:         res_word.half.lo = a[31:0] << b[4:0];
            SRLW:         res_word.half.lo = a[31:0] >> b[4:0];
            SRAW:         res_word.half.lo = $signed(a[31:0]) >>> b[4:0];
            ADDW:         res_word.half.lo = a[31:0] + b[31:0];
            SUBW:         res_word.half.lo = a[31:0] - b[31:0];
            MULW:         res_word.half.lo = product[31:0];
            DIVW:         res_word.half.lo = quot_s[31:0];
            DIVUW:        res_word.half.lo = quot_u[31:0];
            REMW:         res_word.half.lo = rem_s[31:0];
            REMUW:        res_word.half.lo = rem_u[31:0];
            default:      res_word = '0;
        endcase
    end

    assign is_word = op.ctrl inside {SLLW, SRLW, SRAW, ADDW, SUBW, MULW,
                                     DIVW, DIVUW, REMW, REMUW};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
            res.ctrl  <= NOP;
        end else begin
            res.valid <= op.valid;
            res.ctrl  <= op.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        res.trap    <= op.trap;     // Carried along untouched
        res.rd      <= op.rd;
        res.is_word <= is_word;
        res.src1    <= res_word;
    end

    assign res.src2 = '0;

endmodule

`default_nettype wire

// File: hw/exec_op_if.sv
`default_nettype none

interface exec_op_if
    import exec_pkg::*;
();

    logic            valid;
    trap_e           trap;
    exe_op_e         ctrl;
    logic [4:0]      rd;
    exe_word_u       src1;      // First operand, or the raw result after the ALU
    logic [XLEN-1:0] src2;
    logic            is_word;   // Result sits in the lower half and needs sign extension

    modport send (
        output valid,
        output trap,
        output ctrl,
        output rd,
        output src1,
        output src2,
        output is_word
    );

    modport recv (
        input valid,
        input trap,
        input ctrl,
        input rd,
        input src1,
        input src2,
        input is_word
    );

endinterface

`default_nettype wire

// File: hw/exec_operand_select.sv
`default_nettype none

module exec_operand_select
    import exec_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  trap_e           in_trap,
    input  exe_op_e         in_ctrl,
    input  exe_src_e        in_src,
    input  logic [4:0]      in_rd,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] csr_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] zimm,
    input  logic [XLEN-1:0] pc,
    exec_op_if.send         op
);

    logic [XLEN-1:0] sel_a;
    logic [XLEN-1:0] sel_b;
    logic            live;

    assign live = in_valid && (in_ctrl != NOP); // Only a real operation gets operands

    always_comb begin
        sel_a = '0;
        sel_b = '0;
        if (live) begin
            case (in_src)
                R_R: begin
                    sel_a = rs1_data;
                    sel_b = rs2_data;
                end
                R_I: begin
                    sel_a = rs1_data;
                    sel_b = imm;
                end
                PC_I: begin
                    sel_a = pc;
                    sel_b = imm;
                end
                R_CSR: begin
                    sel_a = rs1_data;
                    sel_b = csr_data;
                end
                NOTR_CSR: begin
                    sel_a = ~rs1_data;  // Inverted mask, so AND clears the bits
                    sel_b = csr_data;
                end
                CSR_ZIMM: begin
                    sel_a = csr_data;
                    sel_b = zimm;
                end
                CSR_NOTZIMM: begin
                    sel_a = csr_data;
                    sel_b = ~zimm;
                end
                default: begin
                    sel_a = '0;
                    sel_b = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op.valid <= 1'b0;
            op.ctrl  <= NOP;
        end else begin
            op.valid <= in_valid;
            // An empty slot travels on as NOP so that its data comes out zero
            op.ctrl  <= in_valid ? in_ctrl : NOP;
        end
    end

    always_ff @(posedge clk) begin
        op.trap      <= in_trap;
        op.rd        <= in_rd;
        op.src1.full <= sel_a;
        op.src2      <= sel_b;
    end

    assign op.is_word = 1'b0;   // Width is only known once the ALU decodes ctrl

endmodule

`default_nettype wire

// File: hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN = 64;

    // ====================
    // Operation codes
    // ====================

    typedef enum logic [4:0] {
        NOP,
        SLL,
        SRL,
        SRA,
        ADD,
        SUB,
        XOR,
        OR,
        AND,
        SLT,
        SLTU,
        MUL,
        MULH,
        MULHSU,
        DIV,
        DIVU,
        REM,
        REMU,
        SLLW,       // Everything from here on is a 32-bit W operation
        SRLW,
        SRAW,
        ADDW,
        SUBW,
        MULW,
        DIVW,
        DIVUW,
        REMW,
        REMUW
    } exe_op_e;

    // ====================
    // Operand pairs
    // ====================

    typedef enum logic [2:0] {
        SRC_NOP,
        R_R,
        R_I,
        PC_I,
        R_CSR,
        NOTR_CSR,   // Operand pair for CSR clear with a register mask
        CSR_ZIMM,
        CSR_NOTZIMM // Operand pair for CSR clear with the immediate mask
    } exe_src_e;

    // Trap codes are only carried along, the stage tests them against zero
    typedef logic [3:0] trap_e;

    localparam trap_e TRAP_NONE = 4'd0;

    // One data word, read whole or as two 32-bit halves
    typedef union packed {
        logic [XLEN-1:0] full;
        struct packed {
            logic [31:0] hi;
            logic [31:0] lo;
        } half;
    } exe_word_u;

endpackage

`default_nettype wire

// File: hw/exec_result_format.sv
`default_nettype none

module exec_result_format
    import exec_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    exec_op_if.recv         res,
    output logic            out_valid,
    output logic [4:0]      out_rd,
    output logic [XLEN-1:0] out_data
);

    logic [XLEN-1:0] ext_data;
    logic            squash;

    // W results only fill the lower half
    assign ext_data = res.is_word ? {{32{res.src1.half.lo[31]}}, res.src1.half.lo}
                                  : res.src1.full;

    // Trapped and NOP slots still leave the stage, with zero data
    assign squash = (res.trap != TRAP_NONE) || (res.ctrl == NOP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= res.valid;
            out_data  <= squash ? '0 : ext_data;
        end
    end

    always_ff @(posedge clk) begin
        out_rd <= res.rd;
    end

endmodule

`default_nettype wire

// File: hw/exec_stage_top.sv
`default_nettype none

module exec_stage_top
    import exec_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  trap_e           in_trap,
    input  exe_op_e         in_ctrl,
    input  exe_src_e        in_src,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] csr_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] zimm,
    input  logic [XLEN-1:0] pc,
    input  logic [4:0]      in_rd,
    output logic            out_valid,
    output logic [4:0]      out_rd,
    output logic [XLEN-1:0] out_data
);

    exec_op_if sel_if ();   // Selected operands into the ALU
    exec_op_if alu_if ();   // Raw result into the formatter

    exec_operand_select u_select (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_trap  (in_trap),
        .in_ctrl  (in_ctrl),
        .in_src   (in_src),
        .in_rd    (in_rd),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .csr_data (csr_data),
        .imm      (imm),
        .zimm     (zimm),
        .pc       (pc),
        .op       (sel_if.send)
    );

    exec_alu u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (sel_if.recv),
        .res   (alu_if.send)
    );

    exec_result_format u_format (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (alu_if.recv),
        .out_valid (out_valid),
        .out_rd    (out_rd),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire
